/* logic/fetch_config.svh */
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

//////////////////////////////
// datapath widths
//////////////////////////////

// address and data width
`define XLEN            32
// instructions delivered per fetch
`define FETCH_WIDTH     2
`define INST_BITS       32

//////////////////////////////
// predictor table sizes
//////////////////////////////

// target buffer depth, indexed from pc bit 2
`define BTB_ENTRIES     64
`define BTB_TAG_BITS    10
// low target bits kept per entry, above the byte offset
`define BTB_TARGET_BITS 12

// local history registers, one per pc index
`define BHT_ENTRIES     64
`define HIST_BITS       3

`endif

/* logic/fetch_pkg.sv */
`include "fetch_config.svh"

package fetch_pkg;

    //////////////////////////////
    // instruction cache side
    //////////////////////////////

    // request toward the icache
    // address always word aligned
    typedef struct packed {
        logic [`XLEN-1:0] addr;
    } icache_req_t;

    // same-cycle answer from the icache
    // low word is slot 0, high word is slot 1
    typedef struct packed {
        logic                                   valid;
        logic [`FETCH_WIDTH*`INST_BITS-1:0]     data;
    } icache_rsp_t;

    //////////////////////////////
    // toward the instruction buffer
    //////////////////////////////

    // one fetched instruction with its pc pair
    typedef struct packed {
        logic                   valid;
        logic [`INST_BITS-1:0]  inst;
        logic [`XLEN-1:0]       pc;
        // predicted pc of the instruction that follows
        logic [`XLEN-1:0]       npc;
    } fetch_slot_t;

    // all slots of one fetch
    // index 0 is the oldest instruction
    typedef fetch_slot_t [`FETCH_WIDTH-1:0] fetch_packet_t;

endpackage

/* logic/predict_pkg.sv */
`include "fetch_config.svh"

package predict_pkg;

    //////////////////////////////
    // pattern counter
    //////////////////////////////

    // 2-bit saturating counter
    // upper bit set means predict taken
    typedef enum logic [1:0] {
        CTR_STRONG_NT = 2'd0,
        CTR_WEAK_NT   = 2'd1,
        CTR_WEAK_T    = 2'd2,
        CTR_STRONG_T  = 2'd3
    } counter_t;

    //////////////////////////////
    // execute to predictor
    //////////////////////////////

    // one resolved branch per cycle
    // target only matters when taken
    typedef struct packed {
        logic               valid;
        logic [`XLEN-1:0]   pc;
        logic               taken;
        logic [`XLEN-1:0]   target;
    } resolve_t;

    //////////////////////////////
    // predictor to fetch
    //////////////////////////////

    // per-slot lookup result
    // hit alone marks the slot as a branch
    typedef struct packed {
        logic               hit;
        logic               taken;
        logic [`XLEN-1:0]   target;
    } lookup_t;

endpackage

/* logic/pipe_reg.sv */
`timescale 1ns/1ns

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clock,
    input  logic     reset,
    input  logic     load,
    input  logic     flush,
    input  payload_t data_in,
    output logic     valid,
    output payload_t data_out
);

    logic     valid_q;
    payload_t data_q;

    // one-cycle pulse unless load repeats
    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (flush) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= load;
        end
    end

    // payload only moves on load
    always_ff @(posedge clock) begin
        if (load) begin
            data_q <= data_in;
        end
    end

    assign valid = valid_q;

    // stale payload reads as zero
    // so inner valid fields never outlive the pulse
    always_comb begin
        data_out = '0;
        if (valid_q) begin
            data_out = data_q;
        end
    end

    // redirect and accept are exclusive at the stage boundary
    load_flush_exclusive: assert property (
        @(posedge clock) disable iff (reset) !(load && flush)
    );

endmodule

/* logic/fetch_pc_gen.sv */
`timescale 1ns/1ns

`include "fetch_config.svh"

module fetch_pc_gen (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                if_valid,
    input  logic                                icache_valid,
    input  logic                                take_branch,
    input  logic [`XLEN-1:0]                    branch_target,
    input  logic [`XLEN-1:0]                    predicted_pc,
    output logic                                accept,
    output logic [`XLEN-1:0]                    pc,
    output logic [`FETCH_WIDTH-1:0][`XLEN-1:0]  slot_pc,
    output fetch_pkg::icache_req_t              icache_req
);

    localparam logic [`XLEN-1:0] INST_BYTES = `INST_BITS / 8;

    logic [`XLEN-1:0] pc_q;
    logic [`XLEN-1:0] step_pc;

    //////////////////////////////
    // accept and pc register
    //////////////////////////////

    // redirect from execute wins over any fetch
    assign accept = icache_valid && if_valid && !take_branch;

    always_ff @(posedge clock) begin
        if (reset) begin
            pc_q <= '0;
        end else if (take_branch) begin
            pc_q <= branch_target;
        end else if (accept) begin
            pc_q <= predicted_pc;
        end
    end

    assign pc = pc_q;

    // pcs of each slot for the table lookups
    always_comb begin
        step_pc = pc_q;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            slot_pc[i] = step_pc;
            step_pc    = step_pc + INST_BYTES;
        end
    end

    //////////////////////////////
    // icache request
    //////////////////////////////

    // byte offset dropped
    assign icache_req.addr = {pc_q[`XLEN-1:2], 2'b00};

    // targets from execute and the btb must keep the pc aligned
    pc_aligned: assert property (
        @(posedge clock) disable iff (reset) pc_q[1:0] == 2'b00
    );

endmodule

/* logic/branch_target_buffer.sv */
`timescale 1ns/1ns

`include "fetch_config.svh"

module branch_target_buffer (
    input  logic                                clock,
    input  logic                                reset,
    input  logic [`FETCH_WIDTH-1:0][`XLEN-1:0]  lookup_pc,
    input  predict_pkg::resolve_t               update,
    output logic [`FETCH_WIDTH-1:0]             hit,
    output logic [`FETCH_WIDTH-1:0][`XLEN-1:0]  target
);

    localparam int IDX_BITS = $clog2(`BTB_ENTRIES);
    // tag sits right above the index
    localparam int TAG_LSB  = 2 + IDX_BITS;
    // lookup pc supplies the target bits above this
    localparam int HIGH_LSB = 2 + `BTB_TARGET_BITS;

    typedef struct packed {
        logic [`BTB_TAG_BITS-1:0]    tag;
        logic [`BTB_TARGET_BITS-1:0] target;
    } btb_entry_t;

    btb_entry_t              entries [`BTB_ENTRIES];
    logic [`BTB_ENTRIES-1:0] entry_valid;

    logic                    wr_en;
    logic [IDX_BITS-1:0]     wr_idx;
    logic [IDX_BITS-1:0]     rd_idx [`FETCH_WIDTH];
    btb_entry_t              rd_entry [`FETCH_WIDTH];

    //////////////////////////////
    // update from execute
    //////////////////////////////

    // only taken branches allocate
    assign wr_en  = update.valid && update.taken;
    assign wr_idx = update.pc[2 +: IDX_BITS];

    always_ff @(posedge clock) begin
        if (reset) begin
            entry_valid <= '0;
        end else if (wr_en) begin
            entry_valid[wr_idx] <= 1'b1;
        end
    end

    // tag and target storage
    always_ff @(posedge clock) begin
        if (wr_en) begin
            entries[wr_idx].tag    <= update.pc[TAG_LSB +: `BTB_TAG_BITS];
            entries[wr_idx].target <= update.target[2 +: `BTB_TARGET_BITS];
        end
    end

    //////////////////////////////
    // lookups
    //////////////////////////////

    always_comb begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            rd_idx[i]   = lookup_pc[i][2 +: IDX_BITS];
            rd_entry[i] = entries[rd_idx[i]];
            hit[i]      = entry_valid[rd_idx[i]]
                       && (rd_entry[i].tag == lookup_pc[i][TAG_LSB +: `BTB_TAG_BITS]);
            // near target with high bits borrowed from the fetch pc
            target[i]   = {lookup_pc[i][`XLEN-1:HIGH_LSB], rd_entry[i].target, 2'b00};
        end
    end

endmodule

/* logic/history_predictor.sv */
`timescale 1ns/1ns

`include "fetch_config.svh"

module history_predictor (
    input  logic                                clock,
    input  logic                                reset,
    input  logic [`FETCH_WIDTH-1:0][`XLEN-1:0]  lookup_pc,
    input  predict_pkg::resolve_t               update,
    output logic [`FETCH_WIDTH-1:0]             taken
);

    localparam int IDX_BITS = $clog2(`BHT_ENTRIES);
    localparam int PATTERNS = 1 << `HIST_BITS;

    // local history per pc index
    logic [`HIST_BITS-1:0]  history [`BHT_ENTRIES];
    // one counter per index and history pattern
    predict_pkg::counter_t  counters [`BHT_ENTRIES][PATTERNS];

    logic [IDX_BITS-1:0]    wr_idx;
    logic [`HIST_BITS-1:0]  wr_hist;
    predict_pkg::counter_t  upd_ctr;
    predict_pkg::counter_t  next_ctr;

    logic [IDX_BITS-1:0]    rd_idx [`FETCH_WIDTH];
    predict_pkg::counter_t  rd_ctr [`FETCH_WIDTH];

    //////////////////////////////
    // training
    //////////////////////////////

    // counter picked by the history before this outcome
    always_comb begin
        wr_idx  = update.pc[2 +: IDX_BITS];
        wr_hist = history[wr_idx];
        upd_ctr = counters[wr_idx][wr_hist];
    end

    // saturating step in both directions
    always_comb begin
        case (upd_ctr)
            predict_pkg::CTR_STRONG_NT:
                next_ctr = update.taken ? predict_pkg::CTR_WEAK_NT : predict_pkg::CTR_STRONG_NT;
            predict_pkg::CTR_WEAK_NT:
                next_ctr = update.taken ? predict_pkg::CTR_WEAK_T : predict_pkg::CTR_STRONG_NT;
            predict_pkg::CTR_WEAK_T:
                next_ctr = update.taken ? predict_pkg::CTR_STRONG_T : predict_pkg::CTR_WEAK_NT;
            predict_pkg::CTR_STRONG_T:
                next_ctr = update.taken ? predict_pkg::CTR_STRONG_T : predict_pkg::CTR_WEAK_T;
            default:
                next_ctr = upd_ctr;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int e = 0; e < `BHT_ENTRIES; e++) begin
                history[e] <= '0;
                for (int p = 0; p < PATTERNS; p++) begin
                    counters[e][p] <= predict_pkg::CTR_WEAK_NT;
                end
            end
        end else if (update.valid) begin
            counters[wr_idx][wr_hist] <= next_ctr;
            // newest outcome enters at bit 0
            history[wr_idx] <= {wr_hist[`HIST_BITS-2:0], update.taken};
        end
    end

    //////////////////////////////
    // lookups
    //////////////////////////////

    always_comb begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            rd_idx[i] = lookup_pc[i][2 +: IDX_BITS];
            rd_ctr[i] = counters[rd_idx[i]][history[rd_idx[i]]];
            taken[i]  = (rd_ctr[i] == predict_pkg::CTR_WEAK_T)
                     || (rd_ctr[i] == predict_pkg::CTR_STRONG_T);
        end
    end

    // a registered resolve must never carry an unknown pc into the tables
    update_counter_known: assert property (
        @(posedge clock) disable iff (reset) update.valid |-> !$isunknown(upd_ctr)
    );

endmodule

/* logic/fetch_pack.sv */
`timescale 1ns/1ns

`include "fetch_config.svh"

module fetch_pack (
    input  logic [`XLEN-1:0]                            pc,
    input  fetch_pkg::icache_rsp_t                      icache_rsp,
    input  predict_pkg::lookup_t [`FETCH_WIDTH-1:0]     lookup,
    output fetch_pkg::fetch_packet_t                    packet,
    output logic [`XLEN-1:0]                            predicted_pc
);

    localparam logic [`XLEN-1:0] INST_BYTES = `INST_BITS / 8;

    // walks slots oldest first
    // cut marks that an older slot already redirects
    always_comb begin
        logic [`XLEN-1:0] slot_pc;
        logic             cut;
        logic             pred_taken;

        slot_pc      = pc;
        cut          = 1'b0;
        predicted_pc = '0;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            // buffer hit doubles as the branch marker
            pred_taken = lookup[i].hit && lookup[i].taken;

            packet[i].valid = icache_rsp.valid && !cut;
            packet[i].inst  = icache_rsp.data[i*`INST_BITS +: `INST_BITS];
            packet[i].pc    = slot_pc;
            packet[i].npc   = pred_taken ? lookup[i].target : slot_pc + INST_BYTES;

            // first predicted-taken slot sets the next fetch
            if (pred_taken && !cut) begin
                predicted_pc = lookup[i].target;
                cut          = 1'b1;
            end
            slot_pc = slot_pc + INST_BYTES;
        end

        // fall through to pc+8 when nothing is taken
        if (!cut) begin
            predicted_pc = slot_pc;
        end
    end

endmodule

/* logic/fetch_top.sv */
`timescale 1ns/1ns

`include "fetch_config.svh"

module fetch_top (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        if_valid,
    input  logic                        take_branch,
    input  logic [`XLEN-1:0]            branch_target,
    input  fetch_pkg::icache_rsp_t      icache_rsp,
    input  predict_pkg::resolve_t       resolve,
    output fetch_pkg::icache_req_t      icache_req,
    output fetch_pkg::fetch_packet_t    ib_packet
);

    logic                                   accept;
    logic [`XLEN-1:0]                       pc;
    logic [`XLEN-1:0]                       predicted_pc;
    logic [`FETCH_WIDTH-1:0][`XLEN-1:0]     slot_pc;
    logic [`FETCH_WIDTH-1:0]                btb_hit;
    logic [`FETCH_WIDTH-1:0][`XLEN-1:0]     btb_target;
    logic [`FETCH_WIDTH-1:0]                bht_taken;
    predict_pkg::lookup_t [`FETCH_WIDTH-1:0] lookup;
    fetch_pkg::fetch_packet_t               packet;
    predict_pkg::resolve_t                  resolve_q;

    //////////////////////////////
    // pc and icache request
    //////////////////////////////

    fetch_pc_gen u_pc_gen (
        .clock          (clock),
        .reset          (reset),
        .if_valid       (if_valid),
        .icache_valid   (icache_rsp.valid),
        .take_branch    (take_branch),
        .branch_target  (branch_target),
        .predicted_pc   (predicted_pc),
        .accept         (accept),
        .pc             (pc),
        .slot_pc        (slot_pc),
        .icache_req     (icache_req)
    );

    //////////////////////////////
    // prediction tables
    //////////////////////////////

    // both tables train from the registered resolve
    branch_target_buffer u_btb (
        .clock      (clock),
        .reset      (reset),
        .lookup_pc  (slot_pc),
        .update     (resolve_q),
        .hit        (btb_hit),
        .target     (btb_target)
    );

    history_predictor u_history (
        .clock      (clock),
        .reset      (reset),
        .lookup_pc  (slot_pc),
        .update     (resolve_q),
        .taken      (bht_taken)
    );

    // gather per-slot lookup results
    for (genvar i = 0; i < `FETCH_WIDTH; i++) begin : g_lookup
        assign lookup[i].hit    = btb_hit[i];
        assign lookup[i].taken  = bht_taken[i];
        assign lookup[i].target = btb_target[i];
    end

    fetch_pack u_pack (
        .pc             (pc),
        .icache_rsp     (icache_rsp),
        .lookup         (lookup),
        .packet         (packet),
        .predicted_pc   (predicted_pc)
    );

    //////////////////////////////
    // output and resolve registers
    //////////////////////////////

    // redirect drops whatever packet is held
    pipe_reg #(
        .payload_t  (fetch_pkg::fetch_packet_t)
    ) u_slot_reg (
        .clock      (clock),
        .reset      (reset),
        .load       (accept),
        .flush      (take_branch),
        .data_in    (packet),
        .valid      (),
        .data_out   (ib_packet)
    );

    // resolve is never cancelled
    pipe_reg #(
        .payload_t  (predict_pkg::resolve_t)
    ) u_resolve_reg (
        .clock      (clock),
        .reset      (reset),
        .load       (resolve.valid),
        .flush      (1'b0),
        .data_in    (resolve),
        .valid      (),
        .data_out   (resolve_q)
    );

endmodule

/* bench/fetch_checks.svh */
`ifndef FETCH_CHECKS_SVH
`define FETCH_CHECKS_SVH

//////////////////////////////
// result counters
//////////////////////////////

int checks = 0;
int errors = 0;

// whole slot against the reference
task automatic check_slot(
    input string                  name,
    input fetch_pkg::fetch_slot_t got,
    input fetch_pkg::fetch_slot_t exp
);
    string got_text;
    checks++;
    if (got !== exp) begin
        errors++;
        got_text = $sformatf("v=%0b inst=%h pc=%h npc=%h",
                             got.valid, got.inst, got.pc, got.npc);
        $display("Error at %0t ns: %s got %s expected v=%0b inst=%h pc=%h npc=%h",
                 $time, name, got_text, exp.valid, exp.inst, exp.pc, exp.npc);
    end
endtask

// addresses and pcs
task automatic check_pc(
    input string            name,
    input logic [`XLEN-1:0] got,
    input logic [`XLEN-1:0] exp
);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("Error at %0t ns: %s got %h expected %h", $time, name, got, exp);
    end
endtask

// single valid bits
task automatic check_valid(
    input string name,
    input logic  got,
    input logic  exp
);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("Error at %0t ns: %s got %0b expected %0b", $time, name, got, exp);
    end
endtask

// one line per finished test
task automatic finish_test(input string name, input int first_error);
    $display("test %s done, %0d errors", name, errors - first_error);
endtask

`endif

/* bench/fetch_tb.sv */
`timescale 1ns/1ns

`include "fetch_config.svh"

module fetch_tb;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 4;
    localparam int SEQ_PACKETS  = 4;
    localparam int STALL_CYCLES = 32;
    localparam int MAX_TRAIN    = 10;
    localparam int PACKET_WAIT  = 8;
    // rough cycle budget of all tests together
    localparam int TEST_CYCLES  = RESET_CYCLES + SEQ_PACKETS + 2 + STALL_CYCLES + 2
                                + PACKET_WAIT + 8 + 3 * (2 * MAX_TRAIN + 8);
    localparam int WATCHDOG_NS  = (2 * TEST_CYCLES + 50) * CLK_PERIOD;
    localparam int BTB_IDX      = $clog2(`BTB_ENTRIES);
    localparam int BHT_IDX      = $clog2(`BHT_ENTRIES);
    localparam int MEM_WORDS    = 1024;

    localparam logic [`XLEN-1:0] REDIRECT_PC = 32'h100;
    localparam logic [`XLEN-1:0] SLOT0_BR    = 32'h40;
    localparam logic [`XLEN-1:0] SLOT0_TGT   = 32'h120;
    localparam logic [`XLEN-1:0] SLOT1_BR    = 32'h84;
    localparam logic [`XLEN-1:0] SLOT1_TGT   = 32'h180;

    logic                       clock;
    logic                       reset;
    logic                       if_valid;
    logic                       cache_valid;
    logic                       take_branch;
    logic [`XLEN-1:0]           branch_target;
    fetch_pkg::icache_rsp_t     icache_rsp;
    predict_pkg::resolve_t      resolve;
    fetch_pkg::icache_req_t     icache_req;
    fetch_pkg::fetch_packet_t   ib_packet;

    // 4 KB of icache contents
    logic [`INST_BITS-1:0]      mem [MEM_WORDS];
    logic [9:0]                 word_idx;
    int                         seed = 32'hf07a;

    // reference tables
    logic                        m_btb_valid  [`BTB_ENTRIES];
    logic [`BTB_TAG_BITS-1:0]    m_btb_tag    [`BTB_ENTRIES];
    logic [`BTB_TARGET_BITS-1:0] m_btb_target [`BTB_ENTRIES];
    logic [`HIST_BITS-1:0]       m_hist       [`BHT_ENTRIES];
    int                          m_ctr        [`BHT_ENTRIES][1 << `HIST_BITS];
    // pc of the next packet the DUT should deliver
    logic [`XLEN-1:0]            exp_pc;

`include "fetch_checks.svh"

    fetch_top u_fetch_top (
        .clock          (clock),
        .reset          (reset),
        .if_valid       (if_valid),
        .take_branch    (take_branch),
        .branch_target  (branch_target),
        .icache_rsp     (icache_rsp),
        .resolve        (resolve),
        .icache_req     (icache_req),
        .ib_packet      (ib_packet)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    //////////////////////////////
    // icache model
    //////////////////////////////

    // same-cycle answer with two words from the aligned address
    assign word_idx = icache_req.addr[11:2];

    always_comb begin
        icache_rsp.valid = cache_valid;
        icache_rsp.data  = {mem[word_idx + 10'd1], mem[word_idx]};
    end

    function automatic logic [`INST_BITS-1:0] mem_word(input logic [`XLEN-1:0] addr);
        return mem[addr[11:2]];
    endfunction

    //////////////////////////////
    // reference predictor
    //////////////////////////////

    // hit in the buffer and counter in a taken state
    function automatic logic model_taken(input logic [`XLEN-1:0] pc);
        logic [BTB_IDX-1:0] b;
        logic [BHT_IDX-1:0] h;
        b = pc[2 +: BTB_IDX];
        h = pc[2 +: BHT_IDX];
        return m_btb_valid[b] && (m_btb_tag[b] == pc[BTB_IDX + 2 +: `BTB_TAG_BITS])
            && (m_ctr[h][m_hist[h]] >= 2);
    endfunction

    // upper bits come from the looked-up pc
    function automatic logic [`XLEN-1:0] model_target(input logic [`XLEN-1:0] pc);
        return {pc[`XLEN-1:`BTB_TARGET_BITS + 2], m_btb_target[pc[2 +: BTB_IDX]], 2'b00};
    endfunction

    function automatic void model_resolve(
        input logic [`XLEN-1:0] pc,
        input logic             taken,
        input logic [`XLEN-1:0] target
    );
        logic [BTB_IDX-1:0] b;
        logic [BHT_IDX-1:0] h;
        b = pc[2 +: BTB_IDX];
        h = pc[2 +: BHT_IDX];
        // only taken outcomes allocate
        if (taken) begin
            m_btb_valid[b]  = 1'b1;
            m_btb_tag[b]    = pc[BTB_IDX + 2 +: `BTB_TAG_BITS];
            m_btb_target[b] = target[2 +: `BTB_TARGET_BITS];
        end
        // counter under the old history saturates at 0 and 3
        if (taken && m_ctr[h][m_hist[h]] < 3) begin
            m_ctr[h][m_hist[h]] += 1;
        end else if (!taken && m_ctr[h][m_hist[h]] > 0) begin
            m_ctr[h][m_hist[h]] -= 1;
        end
        m_hist[h] = {m_hist[h][`HIST_BITS-2:0], taken};
    endfunction

    //////////////////////////////
    // driver and checker tasks
    //////////////////////////////

    task automatic wait_packet(input string what);
        int n;
        n = 0;
        @(negedge clock);
        while (!ib_packet[0].valid && n < PACKET_WAIT) begin
            @(negedge clock);
            n++;
        end
        if (!ib_packet[0].valid) begin
            errors++;
            $display("no packet for %s within %0d cycles", what, PACKET_WAIT);
        end
    endtask

    // compare the held packet with the reference and step exp_pc
    task automatic expect_packet();
        fetch_pkg::fetch_slot_t s0;
        fetch_pkg::fetch_slot_t s1;
        logic                   br0;
        logic                   br1;
        br0      = model_taken(exp_pc);
        br1      = model_taken(exp_pc + 4);
        s0.valid = 1'b1;
        s0.inst  = mem_word(exp_pc);
        s0.pc    = exp_pc;
        s0.npc   = br0 ? model_target(exp_pc) : exp_pc + 4;
        // a taken slot 0 cuts slot 1
        s1.valid = !br0;
        s1.inst  = mem_word(exp_pc + 4);
        s1.pc    = exp_pc + 4;
        s1.npc   = br1 ? model_target(exp_pc + 4) : exp_pc + 8;
        check_slot("ib_packet[0]", ib_packet[0], s0);
        check_slot("ib_packet[1]", ib_packet[1], s1);
        if (br0) begin
            exp_pc = s0.npc;
        end else if (br1) begin
            exp_pc = s1.npc;
        end else begin
            exp_pc = exp_pc + 8;
        end
        check_pc("icache_req.addr", icache_req.addr, exp_pc);
    endtask

    // n back-to-back fetches with if_valid dropped at the last accept
    task automatic run_fetch(input int n);
        @(posedge clock);
        if_valid <= 1'b1;
        for (int k = 0; k < n; k++) begin
            @(posedge clock);
            if (k == n - 1) begin
                if_valid <= 1'b0;
            end
            wait_packet("fetch");
            expect_packet();
        end
        // pulse ends with no further accept
        @(negedge clock);
        check_valid("ib_packet[0].valid", ib_packet[0].valid, 1'b0);
    endtask

    // registered at the first edge and written to the tables at the second
    task automatic apply_resolve(
        input logic [`XLEN-1:0] pc,
        input logic             taken,
        input logic [`XLEN-1:0] target
    );
        predict_pkg::resolve_t r;
        r.valid  = 1'b1;
        r.pc     = pc;
        r.taken  = taken;
        r.target = target;
        @(posedge clock);
        resolve <= r;
        @(posedge clock);
        resolve <= '0;
        model_resolve(pc, taken, target);
    endtask

    task automatic train_branch(
        input logic [`XLEN-1:0] pc,
        input logic [`XLEN-1:0] target,
        input logic             want
    );
        int n;
        n = 0;
        while (model_taken(pc) != want && n < MAX_TRAIN) begin
            apply_resolve(pc, want, target);
            n++;
        end
        if (model_taken(pc) != want) begin
            errors++;
            $display("branch at %h did not train within %0d resolves", pc, MAX_TRAIN);
        end
    endtask

    // redirect while fetch is idle
    task automatic redirect_to(input logic [`XLEN-1:0] target);
        @(posedge clock);
        take_branch   <= 1'b1;
        branch_target <= target;
        @(posedge clock);
        take_branch   <= 1'b0;
        exp_pc = target;
        @(negedge clock);
        check_valid("ib_packet[0].valid", ib_packet[0].valid, 1'b0);
        check_pc("icache_req.addr", icache_req.addr, target);
    endtask

    //////////////////////////////
    // tests
    //////////////////////////////

    task automatic test_sequential();
        int first;
        first = errors;
        run_fetch(SEQ_PACKETS);
        finish_test("sequential", first);
    endtask

    task automatic test_stall();
        int          first;
        logic [31:0] r;
        logic        accepted;
        first = errors;
        for (int c = 0; c < STALL_CYCLES; c++) begin
            @(posedge clock);
            // levels seen by the DUT at this edge
            accepted = if_valid && cache_valid;
            r = $random(seed);
            if (c == STALL_CYCLES - 1) begin
                if_valid    <= 1'b0;
                cache_valid <= 1'b1;
            end else begin
                if_valid    <= r[0];
                cache_valid <= r[1];
            end
            @(negedge clock);
            if (accepted) begin
                expect_packet();
            end else begin
                check_valid("ib_packet[0].valid", ib_packet[0].valid, 1'b0);
                check_pc("icache_req.addr", icache_req.addr, exp_pc);
            end
        end
        finish_test("stall", first);
    endtask

    task automatic test_redirect();
        int first;
        first = errors;
        @(posedge clock);
        if_valid <= 1'b1;
        @(posedge clock);
        wait_packet("redirect lead-in");
        expect_packet();
        // one more accept before the strobe is seen
        @(posedge clock);
        take_branch   <= 1'b1;
        branch_target <= REDIRECT_PC;
        wait_packet("redirect lead-in");
        expect_packet();
        @(posedge clock);
        take_branch <= 1'b0;
        exp_pc = REDIRECT_PC;
        // flushed cycle
        @(negedge clock);
        check_valid("ib_packet[0].valid", ib_packet[0].valid, 1'b0);
        check_pc("icache_req.addr", icache_req.addr, REDIRECT_PC);
        wait_packet("redirect target");
        check_pc("ib_packet[0].pc", ib_packet[0].pc, REDIRECT_PC);
        expect_packet();
        @(posedge clock);
        if_valid <= 1'b0;
        wait_packet("redirect tail");
        expect_packet();
        finish_test("redirect", first);
    endtask

    task automatic test_train_taken();
        int first;
        first = errors;
        train_branch(SLOT0_BR, SLOT0_TGT, 1'b1);
        redirect_to(SLOT0_BR);
        run_fetch(1);
        check_pc("icache_req.addr", icache_req.addr, SLOT0_TGT);
        run_fetch(2);
        finish_test("train taken", first);
    endtask

    task automatic test_slot1_retrain();
        int first;
        first = errors;
        train_branch(SLOT1_BR, SLOT1_TGT, 1'b1);
        redirect_to(SLOT1_BR - 4);
        run_fetch(1);
        check_pc("icache_req.addr", icache_req.addr, SLOT1_TGT);
        run_fetch(1);
        // back to not taken so fetch falls through
        train_branch(SLOT1_BR, SLOT1_TGT, 1'b0);
        redirect_to(SLOT1_BR - 4);
        run_fetch(1);
        check_pc("icache_req.addr", icache_req.addr, SLOT1_BR + 4);
        run_fetch(1);
        finish_test("slot 1 retrain", first);
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        logic [`XLEN-1:0] addr;
        reset         = 1'b1;
        if_valid      = 1'b0;
        cache_valid   = 1'b1;
        take_branch   = 1'b0;
        branch_target = '0;
        resolve       = '0;
        exp_pc        = '0;
        // word contents follow the byte address
        for (int i = 0; i < MEM_WORDS; i++) begin
            addr   = i * 4;
            mem[i] = {~addr[15:0], addr[15:0]};
        end
        for (int e = 0; e < `BTB_ENTRIES; e++) begin
            m_btb_valid[e] = 1'b0;
        end
        // weak not-taken everywhere
        for (int e = 0; e < `BHT_ENTRIES; e++) begin
            m_hist[e] = '0;
            for (int p = 0; p < (1 << `HIST_BITS); p++) begin
                m_ctr[e][p] = 1;
            end
        end
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;

        test_sequential();
        test_stall();
        test_redirect();
        test_train_taken();
        test_slot1_retrain();

        repeat (2) @(posedge clock);
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // hang guard
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, tests did not finish", WATCHDOG_NS);
        $display("** FAIL **");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+logic
+incdir+bench
logic/fetch_pkg.sv
logic/predict_pkg.sv
logic/pipe_reg.sv
logic/fetch_pc_gen.sv
logic/branch_target_buffer.sv
logic/history_predictor.sv
logic/fetch_pack.sv
logic/fetch_top.sv
bench/fetch_tb.sv

/* run.sh */
#!/bin/sh
# build and run the fetch testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module fetch_tb \
    -f vlog.f \
    -o fetch_sim

./obj_dir/fetch_sim | tee sim.log

if grep -q -F "** PASS **" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
